// File: verilog/bp_config.svh
`ifndef BP_CONFIG_SVH
`define BP_CONFIG_SVH

// branch target buffer depth, power of two
`define BTB_ENTRIES 32

// entries in each direction table
// bimodal, gshare and chooser share this depth
`define BHT_ENTRIES 256

// global history length in resolved cond branches
`define HIST_BITS 8

// width of every performance counter
`define CNT_WIDTH 32

`endif

// File: verilog/bp_pkg.sv
`default_nettype none

`include "bp_config.svh"

package bp_pkg;

    // program counter, byte address
    typedef logic [31:0] pc_t;

    // control-flow kind as decoded by execute
    // none also marks an empty btb slot kind
    typedef enum logic [1:0] {
        br_none = 2'd0,
        br_cond = 2'd1,
        br_jal  = 2'd2,
        br_jalr = 2'd3
    } br_kind_e;

    // global history, newest outcome in bit 0
    typedef logic [`HIST_BITS-1:0] ghist_t;

    // one performance counter
    typedef logic [`CNT_WIDTH-1:0] cnt_t;

    // prediction handed to fetch
    // comes back untouched inside the resolve record
    typedef struct packed {
        logic     taken;
        pc_t      target;
        logic     btb_hit;
        br_kind_e kind;
        // history seen at lookup, used to retrain gshare
        ghist_t   ghist;
        logic     use_gshare;
        logic     bim_taken;
        logic     gsh_taken;
    } pred_t;

    // actual outcome reported by execute
    typedef struct packed {
        pc_t      pc;
        br_kind_e kind;
        logic     taken;
        pc_t      target;
        pred_t    pred;
    } resolve_t;

    // counter bundle
    typedef struct packed {
        cnt_t total_br;
        cnt_t total_jalr;
        cnt_t dir_correct;
        cnt_t target_correct;
        cnt_t stall_cycles;
        cnt_t flushes;
    } perf_t;

endpackage

`default_nettype wire

// File: verilog/btb.sv
`timescale 1ns/1ps
`default_nettype none

`include "bp_config.svh"

module btb (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             lookup_en,
    input  bp_pkg::pc_t      lookup_pc,
    output logic             hit,
    output bp_pkg::br_kind_e hit_kind,
    output bp_pkg::pc_t      hit_target,
    input  logic             upd_en,
    input  bp_pkg::pc_t      upd_pc,
    input  bp_pkg::br_kind_e upd_kind,
    input  bp_pkg::pc_t      upd_target
);
    import bp_pkg::*;

    localparam int IDX_BITS = $clog2(`BTB_ENTRIES);
    localparam int TAG_BITS = 32 - IDX_BITS - 2;

    // entry storage
    logic                valid_q  [`BTB_ENTRIES];
    logic [TAG_BITS-1:0] tag_q    [`BTB_ENTRIES];
    br_kind_e            kind_q   [`BTB_ENTRIES];
    pc_t                 target_q [`BTB_ENTRIES];

    logic [IDX_BITS-1:0] rd_idx;
    logic [TAG_BITS-1:0] rd_tag;
    logic [IDX_BITS-1:0] wr_idx;
    logic [TAG_BITS-1:0] wr_tag;
    logic                rd_match;

    // word index, byte offset dropped
    assign rd_idx = lookup_pc[IDX_BITS+1:2];
    assign rd_tag = lookup_pc[31:IDX_BITS+2];
    assign wr_idx = upd_pc[IDX_BITS+1:2];
    assign wr_tag = upd_pc[31:IDX_BITS+2];

    // read of old contents, a same-edge write lands after
    assign rd_match = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);

    // valid bits
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `BTB_ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (upd_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // tag, kind and target, overwritten on every taken resolve
    always_ff @(posedge clk) begin
        if (upd_en) begin
            tag_q[wr_idx]    <= wr_tag;
            kind_q[wr_idx]   <= upd_kind;
            target_q[wr_idx] <= upd_target;
        end
    end

    // registered lookup result, held while lookup_en is low
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hit      <= 1'b0;
            hit_kind <= br_none;
        end else if (lookup_en) begin
            hit      <= rd_match;
            hit_kind <= kind_q[rd_idx];
        end
    end

    // target payload
    always_ff @(posedge clk) begin
        if (lookup_en) begin
            hit_target <= target_q[rd_idx];
        end
    end

endmodule

`default_nettype wire

// File: verilog/tournament_pred.sv
`timescale 1ns/1ps
`default_nettype none

`include "bp_config.svh"

module tournament_pred (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             lookup_en,
    input  bp_pkg::pc_t      lookup_pc,
    output logic             pred_taken,
    output logic             use_gshare,
    output logic             bim_taken,
    output logic             gsh_taken,
    output bp_pkg::ghist_t   ghist,
    input  logic             upd_en,
    input  bp_pkg::resolve_t resolve
);
    import bp_pkg::*;

    localparam int IDX_BITS = $clog2(`BHT_ENTRIES);

    // 2-bit counter tables
    // direction tables: msb set means taken
    // chooser: msb set means trust gshare
    logic [1:0] bim_q [`BHT_ENTRIES];
    logic [1:0] gsh_q [`BHT_ENTRIES];
    logic [1:0] cho_q [`BHT_ENTRIES];

    // global history, moves only on cond resolves
    ghist_t ghr_q;

    // lookup side
    logic [IDX_BITS-1:0] rd_pc_idx;
    logic [IDX_BITS-1:0] rd_gsh_idx;
    logic                rd_bim;
    logic                rd_gsh;
    logic                rd_use_gsh;

    // update side
    logic [IDX_BITS-1:0] wr_pc_idx;
    logic [IDX_BITS-1:0] wr_gsh_idx;
    logic                wr_cond;
    logic                comp_disagree;
    logic                gsh_was_right;

    // pc word bits xor history, history fitted to the index width
    function automatic logic [IDX_BITS-1:0] gsh_index(pc_t pc, ghist_t h);
        gsh_index = pc[IDX_BITS+1:2] ^ IDX_BITS'(h);
    endfunction

    // saturating step of a 2-bit counter
    function automatic logic [1:0] sat_step(logic [1:0] ctr, logic up);
        logic [1:0] nxt;
        nxt = ctr;
        if (up && (ctr != 2'b11)) begin
            nxt = ctr + 2'b01;
        end else if (!up && (ctr != 2'b00)) begin
            nxt = ctr - 2'b01;
        end
        return nxt;
    endfunction

    assign rd_pc_idx  = lookup_pc[IDX_BITS+1:2];
    assign rd_gsh_idx = gsh_index(lookup_pc, ghr_q);
    assign rd_bim     = bim_q[rd_pc_idx][1];
    assign rd_gsh     = gsh_q[rd_gsh_idx][1];
    assign rd_use_gsh = cho_q[rd_pc_idx][1];

    // rebuild the gshare index from the history this branch was predicted with
    assign wr_pc_idx     = resolve.pc[IDX_BITS+1:2];
    assign wr_gsh_idx    = gsh_index(resolve.pc, resolve.pred.ghist);
    assign wr_cond       = upd_en && (resolve.kind == br_cond);
    assign comp_disagree = resolve.pred.bim_taken != resolve.pred.gsh_taken;
    assign gsh_was_right = resolve.pred.gsh_taken == resolve.taken;

    // table training
    // reset: weakly not taken, weakly bimodal
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `BHT_ENTRIES; i++) begin
                bim_q[i] <= 2'b01;
                gsh_q[i] <= 2'b01;
                cho_q[i] <= 2'b01;
            end
        end else if (wr_cond) begin
            bim_q[wr_pc_idx]  <= sat_step(bim_q[wr_pc_idx], resolve.taken);
            gsh_q[wr_gsh_idx] <= sat_step(gsh_q[wr_gsh_idx], resolve.taken);
            // chooser only learns when the two components split
            if (comp_disagree) begin
                cho_q[wr_pc_idx] <= sat_step(cho_q[wr_pc_idx], gsh_was_right);
            end
        end
    end

    // history shift, newest outcome enters at bit 0
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ghr_q <= '0;
        end else if (wr_cond) begin
            ghr_q <= {ghr_q[`HIST_BITS-2:0], resolve.taken};
        end
    end

    // registered lookup result, frozen during stalls
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pred_taken <= 1'b0;
            use_gshare <= 1'b0;
            bim_taken  <= 1'b0;
            gsh_taken  <= 1'b0;
            ghist      <= '0;
        end else if (lookup_en) begin
            pred_taken <= rd_use_gsh ? rd_gsh : rd_bim;
            use_gshare <= rd_use_gsh;
            bim_taken  <= rd_bim;
            gsh_taken  <= rd_gsh;
            // snapshot travels with the prediction
            ghist      <= ghr_q;
        end
    end

endmodule

`default_nettype wire

// File: verilog/perf_counters.sv
`timescale 1ns/1ps
`default_nettype none

module perf_counters (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             stall,
    input  logic             flush,
    input  logic             resolve_valid,
    input  bp_pkg::resolve_t resolve,
    output bp_pkg::perf_t    perf,
    output logic             halt
);
    import bp_pkg::*;

    logic is_jalr;
    logic dir_ok;
    logic tgt_ok;
    logic self_jump;

    // decode of the resolve record
    assign is_jalr = resolve.kind == br_jalr;

    // direction right regardless of target
    assign dir_ok = resolve.taken == resolve.pred.taken;

    // taken needs a matching predicted target
    // not taken needs a not-taken prediction
    assign tgt_ok = resolve.taken ?
                    (resolve.pred.taken && (resolve.pred.target == resolve.target)) :
                    !resolve.pred.taken;

    // jump to itself, the program's halt idiom
    assign self_jump = resolve.taken && (resolve.target == resolve.pc);

    // pipeline strobes
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            perf.stall_cycles <= '0;
            perf.flushes      <= '0;
        end else begin
            // one count per stalled cycle
            if (stall) begin
                perf.stall_cycles <= perf.stall_cycles + 1'b1;
            end
            if (flush) begin
                perf.flushes <= perf.flushes + 1'b1;
            end
        end
    end

    // resolve stream
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            perf.total_br       <= '0;
            perf.total_jalr     <= '0;
            perf.dir_correct    <= '0;
            perf.target_correct <= '0;
        end else if (resolve_valid) begin
            // every resolve is a control-flow op
            perf.total_br <= perf.total_br + 1'b1;
            if (is_jalr) begin
                perf.total_jalr <= perf.total_jalr + 1'b1;
            end
            if (dir_ok) begin
                perf.dir_correct <= perf.dir_correct + 1'b1;
            end
            if (tgt_ok) begin
                perf.target_correct <= perf.target_correct + 1'b1;
            end
        end
    end

    // sticky halt, cleared only by reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            halt <= 1'b0;
        end else if (resolve_valid && self_jump) begin
            halt <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: verilog/branch_predict_unit.sv
`timescale 1ns/1ps
`default_nettype none

module branch_predict_unit (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             fetch_valid,
    input  bp_pkg::pc_t      fetch_pc,
    input  logic             stall,
    input  logic             flush,
    input  logic             resolve_valid,
    input  bp_pkg::resolve_t resolve,
    output logic             pred_valid,
    output bp_pkg::pred_t    pred,
    output bp_pkg::perf_t    perf,
    output logic             halt
);
    import bp_pkg::*;

    logic     lookup_en;
    logic     btb_upd_en;
    pc_t      lookup_pc_q;
    pc_t      seq_pc;
    logic     pred_dir;

    // btb result
    logic     btb_hit;
    br_kind_e btb_kind;
    pc_t      btb_target;

    // direction result
    logic     tp_taken;
    logic     tp_use_gshare;
    logic     tp_bim_taken;
    logic     tp_gsh_taken;
    ghist_t   tp_ghist;

    // stall freezes both lookup pipes
    assign lookup_en = fetch_valid && !stall;

    // only taken outcomes allocate or refresh a btb entry
    assign btb_upd_en = resolve_valid && resolve.taken;

    // pred_valid held across stalls, dropped on idle cycles
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pred_valid <= 1'b0;
        end else if (!stall) begin
            pred_valid <= fetch_valid;
        end
    end

    // pc of the prediction in flight, for the fall-through
    always_ff @(posedge clk) begin
        if (lookup_en) begin
            lookup_pc_q <= fetch_pc;
        end
    end

    btb i_btb (
        .clk        (clk),
        .rst_n      (rst_n),
        .lookup_en  (lookup_en),
        .lookup_pc  (fetch_pc),
        .hit        (btb_hit),
        .hit_kind   (btb_kind),
        .hit_target (btb_target),
        .upd_en     (btb_upd_en),
        .upd_pc     (resolve.pc),
        .upd_kind   (resolve.kind),
        .upd_target (resolve.target)
    );

    tournament_pred i_tournament_pred (
        .clk        (clk),
        .rst_n      (rst_n),
        .lookup_en  (lookup_en),
        .lookup_pc  (fetch_pc),
        .pred_taken (tp_taken),
        .use_gshare (tp_use_gshare),
        .bim_taken  (tp_bim_taken),
        .gsh_taken  (tp_gsh_taken),
        .ghist      (tp_ghist),
        .upd_en     (resolve_valid),
        .resolve    (resolve)
    );

    perf_counters i_perf_counters (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall         (stall),
        .flush         (flush),
        .resolve_valid (resolve_valid),
        .resolve       (resolve),
        .perf          (perf),
        .halt          (halt)
    );

    assign seq_pc = lookup_pc_q + 32'd4;

    // kind rule
    // jumps always taken, cond follows the chooser, a miss falls through
    always_comb begin
        pred_dir = 1'b0;
        if (btb_hit) begin
            case (btb_kind)
                br_jal, br_jalr: pred_dir = 1'b1;
                br_cond:         pred_dir = tp_taken;
                default:         pred_dir = 1'b0;
            endcase
        end
    end

    // prediction record to fetch
    always_comb begin
        pred.taken      = pred_dir;
        pred.target     = pred_dir ? btb_target : seq_pc;
        pred.btb_hit    = btb_hit;
        pred.kind       = btb_hit ? btb_kind : br_none;
        pred.ghist      = tp_ghist;
        pred.use_gshare = tp_use_gshare;
        pred.bim_taken  = tp_bim_taken;
        pred.gsh_taken  = tp_gsh_taken;
    end

endmodule

`default_nettype wire

// File: verification/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst_n
);

    // free-running clock
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // reset low for a few rising edges, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: verification/bp_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "bp_config.svh"

module bp_tb;
    import bp_pkg::*;

    localparam int CLK_NS      = 40;
    localparam int NUM_TESTS   = 6;
    // cycle budget per test for the watchdog
    localparam int TEST_CYCLES = 200;

    logic     clk;
    logic     rst_n;
    logic     fetch_valid;
    pc_t      fetch_pc;
    logic     stall;
    logic     flush;
    logic     resolve_valid;
    resolve_t resolve;
    logic     pred_valid;
    pred_t    pred;
    perf_t    perf;
    logic     halt;

    int       err_count;
    int       seed;
    // reference state built from the resolves sent so far
    perf_t    exp_perf;
    ghist_t   hist_model;
    logic     exp_halt;
    // trained jal, reused by the stall test
    pc_t      jal_pc;
    pc_t      jal_target;

    // direction table reference, trained by every cond resolve sent
    logic [1:0] bim_model [`BHT_ENTRIES];
    logic [1:0] gsh_model [`BHT_ENTRIES];
    logic [1:0] cho_model [`BHT_ENTRIES];

    tb_clock #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(4)) i_tb_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    branch_predict_unit i_branch_predict_unit (
        .clk           (clk),
        .rst_n         (rst_n),
        .fetch_valid   (fetch_valid),
        .fetch_pc      (fetch_pc),
        .stall         (stall),
        .flush         (flush),
        .resolve_valid (resolve_valid),
        .resolve       (resolve),
        .pred_valid    (pred_valid),
        .pred          (pred),
        .perf          (perf),
        .halt          (halt)
    );

    // all driving and sampling happens on falling edges
    task automatic tick();
        @(negedge clk);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        err_count++;
        $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            report_mismatch(name, 32'(exp), 32'(act));
        end
    endtask

    // every field of the prediction record
    task automatic check_pred(input pred_t exp, input pred_t act);
        if (act.taken !== exp.taken) report_mismatch("pred.taken", 32'(exp.taken), 32'(act.taken));
        if (act.target !== exp.target) report_mismatch("pred.target", exp.target, act.target);
        if (act.btb_hit !== exp.btb_hit) begin
            report_mismatch("pred.btb_hit", 32'(exp.btb_hit), 32'(act.btb_hit));
        end
        if (act.kind !== exp.kind) report_mismatch("pred.kind", 32'(exp.kind), 32'(act.kind));
        if (act.ghist !== exp.ghist) report_mismatch("pred.ghist", 32'(exp.ghist), 32'(act.ghist));
        if (act.use_gshare !== exp.use_gshare) begin
            report_mismatch("pred.use_gshare", 32'(exp.use_gshare), 32'(act.use_gshare));
        end
        if (act.bim_taken !== exp.bim_taken) begin
            report_mismatch("pred.bim_taken", 32'(exp.bim_taken), 32'(act.bim_taken));
        end
        if (act.gsh_taken !== exp.gsh_taken) begin
            report_mismatch("pred.gsh_taken", 32'(exp.gsh_taken), 32'(act.gsh_taken));
        end
    endtask

    task automatic check_perf(input perf_t exp, input perf_t act);
        if (act.total_br !== exp.total_br) begin
            report_mismatch("perf.total_br", 32'(exp.total_br), 32'(act.total_br));
        end
        if (act.total_jalr !== exp.total_jalr) begin
            report_mismatch("perf.total_jalr", 32'(exp.total_jalr), 32'(act.total_jalr));
        end
        if (act.dir_correct !== exp.dir_correct) begin
            report_mismatch("perf.dir_correct", 32'(exp.dir_correct), 32'(act.dir_correct));
        end
        if (act.target_correct !== exp.target_correct) begin
            report_mismatch("perf.target_correct", 32'(exp.target_correct),
                            32'(act.target_correct));
        end
        if (act.stall_cycles !== exp.stall_cycles) begin
            report_mismatch("perf.stall_cycles", 32'(exp.stall_cycles), 32'(act.stall_cycles));
        end
        if (act.flushes !== exp.flushes) begin
            report_mismatch("perf.flushes", 32'(exp.flushes), 32'(act.flushes));
        end
    endtask

    // word-aligned random pc
    function automatic pc_t random_pc();
        pc_t v;
        v = pc_t'($random(seed));
        return v & 32'hFFFF_FFFC;
    endfunction

    // random target that never equals pc, so no accidental halt
    function automatic pc_t distinct_target(pc_t pc);
        pc_t t;
        t = random_pc();
        if (t == pc) begin
            t = t + 32'd4;
        end
        return t;
    endfunction

    // bimodal and chooser slot from the word address
    function automatic int pc_slot(pc_t pc);
        return int'((pc >> 2) % `BHT_ENTRIES);
    endfunction

    // gshare slot, word address mixed with a history
    function automatic int hist_slot(pc_t pc, ghist_t h);
        return int'(((pc >> 2) ^ 32'(h)) % `BHT_ENTRIES);
    endfunction

    // 2-bit counter that stops at both ends
    function automatic logic [1:0] saturate(logic [1:0] c, logic up);
        logic [1:0] n;
        if (up) begin
            n = (c == 2'b11) ? c : c + 2'b01;
        end else begin
            n = (c == 2'b00) ? c : c - 2'b01;
        end
        return n;
    endfunction

    // expected prediction from the kind rule, the fall-through rule
    // and the reference direction tables
    function automatic pred_t expect_pred(pc_t pc, logic hit, br_kind_e kind,
                                          logic taken, pc_t target);
        pred_t p;
        p            = '0;
        p.btb_hit    = hit;
        p.kind       = hit ? kind : br_none;
        p.taken      = taken;
        p.target     = taken ? target : pc + 32'd4;
        p.ghist      = hist_model;
        p.use_gshare = cho_model[pc_slot(pc)][1];
        p.bim_taken  = bim_model[pc_slot(pc)][1];
        p.gsh_taken  = gsh_model[hist_slot(pc, hist_model)][1];
        return p;
    endfunction

    // counter, table, history and halt reference for one resolve
    task automatic account(input resolve_t r);
        logic tgt_ok;
        int   slot;
        int   gslot;
        exp_perf.total_br = exp_perf.total_br + 1;
        if (r.kind == br_jalr) exp_perf.total_jalr = exp_perf.total_jalr + 1;
        if (r.taken == r.pred.taken) exp_perf.dir_correct = exp_perf.dir_correct + 1;
        if (r.taken) begin
            tgt_ok = r.pred.taken && (r.pred.target == r.target);
        end else begin
            tgt_ok = !r.pred.taken;
        end
        if (tgt_ok) exp_perf.target_correct = exp_perf.target_correct + 1;
        if (r.kind == br_cond) begin
            slot  = pc_slot(r.pc);
            // gshare entry the prediction actually used
            gslot = hist_slot(r.pc, r.pred.ghist);
            bim_model[slot]  = saturate(bim_model[slot], r.taken);
            gsh_model[gslot] = saturate(gsh_model[gslot], r.taken);
            if (r.pred.bim_taken != r.pred.gsh_taken) begin
                cho_model[slot] = saturate(cho_model[slot], r.pred.gsh_taken == r.taken);
            end
            hist_model = {hist_model[`HIST_BITS-2:0], r.taken};
        end
        if (r.taken && (r.target == r.pc)) exp_halt = 1'b1;
    endtask

    // one-cycle resolve pulse, optionally with a flush in the same cycle
    task automatic send_resolve(input resolve_t r, input logic with_flush);
        resolve       = r;
        resolve_valid = 1'b1;
        flush         = with_flush;
        account(r);
        if (with_flush) exp_perf.flushes = exp_perf.flushes + 1;
        tick();
        resolve_valid = 1'b0;
        flush         = 1'b0;
    endtask

    // one fetch, result sampled a cycle later
    task automatic do_lookup(input pc_t pc, output pred_t got);
        fetch_valid = 1'b1;
        fetch_pc    = pc;
        tick();
        check_bit("pred_valid", 1'b1, pred_valid);
        got         = pred;
        fetch_valid = 1'b0;
    endtask

    task automatic test_reset();
        pc_t   pc;
        pred_t got;
        check_bit("pred_valid", 1'b0, pred_valid);
        check_bit("halt", 1'b0, halt);
        check_perf(exp_perf, perf);
        // empty btb, so a plain fall-through
        pc = random_pc();
        do_lookup(pc, got);
        check_pred(expect_pred(pc, 1'b0, br_none, 1'b0, '0), got);
    endtask

    task automatic test_jal_training();
        resolve_t r;
        pred_t    got;
        jal_pc     = random_pc();
        jal_target = distinct_target(jal_pc);
        r          = '0;
        r.pc       = jal_pc;
        r.kind     = br_jal;
        r.taken    = 1'b1;
        r.target   = jal_target;
        r.pred     = expect_pred(jal_pc, 1'b0, br_none, 1'b0, '0);
        send_resolve(r, 1'b0);
        do_lookup(jal_pc, got);
        check_pred(expect_pred(jal_pc, 1'b1, br_jal, 1'b1, jal_target), got);
    endtask

    task automatic test_cond_training();
        pc_t      cpc;
        pc_t      ctgt;
        resolve_t r;
        pred_t    got;
        // next word, so a different btb slot than the jal
        cpc  = jal_pc + 32'd4;
        ctgt = distinct_target(cpc);
        for (int i = 0; i < `HIST_BITS + 2; i++) begin
            do_lookup(cpc, got);
            r        = '0;
            r.pc     = cpc;
            r.kind   = br_cond;
            r.taken  = 1'b1;
            r.target = ctgt;
            r.pred   = got;
            send_resolve(r, 1'b0);
        end
        do_lookup(cpc, got);
        check_pred(expect_pred(cpc, 1'b1, br_cond, 1'b1, ctgt), got);
        // retrain toward not taken, btb entry stays
        for (int i = 0; i < `HIST_BITS + 2; i++) begin
            do_lookup(cpc, got);
            r        = '0;
            r.pc     = cpc;
            r.kind   = br_cond;
            r.taken  = 1'b0;
            r.target = cpc + 32'd4;
            r.pred   = got;
            send_resolve(r, 1'b0);
        end
        do_lookup(cpc, got);
        check_pred(expect_pred(cpc, 1'b1, br_cond, 1'b0, ctgt), got);
        check_perf(exp_perf, perf);
    endtask

    task automatic test_stall_hold();
        pred_t exp_a;
        exp_a       = expect_pred(jal_pc, 1'b1, br_jal, 1'b1, jal_target);
        fetch_valid = 1'b1;
        fetch_pc    = jal_pc;
        tick();
        check_pred(exp_a, pred);
        // present another pc while stalled
        fetch_pc = jal_pc + 32'd64;
        stall    = 1'b1;
        for (int i = 0; i < 3; i++) begin
            tick();
            exp_perf.stall_cycles = exp_perf.stall_cycles + 1;
            check_bit("pred_valid", 1'b1, pred_valid);
            check_pred(exp_a, pred);
        end
        stall       = 1'b0;
        fetch_valid = 1'b0;
        tick();
        // idle cycle drops the valid
        check_bit("pred_valid", 1'b0, pred_valid);
        check_perf(exp_perf, perf);
    endtask

    // random resolve, any kind, random prediction quality
    task automatic make_random_resolve(output resolve_t r);
        logic [31:0] rnd;
        rnd = $random(seed);
        r   = '0;
        case (rnd[1:0])
            2'd1:    r.kind = br_jal;
            2'd2:    r.kind = br_jalr;
            default: r.kind = br_cond;
        endcase
        r.pc    = random_pc();
        r.taken = (r.kind == br_cond) ? rnd[2] : 1'b1;
        // forward offset keeps the target off its own pc
        r.target = r.taken ? r.pc + {22'd0, rnd[15:8], 2'b00} + 32'd4 : r.pc + 32'd4;
        r.pred.taken   = rnd[3];
        r.pred.btb_hit = rnd[5];
        r.pred.kind    = r.kind;
        r.pred.ghist   = hist_model;
        if (rnd[3]) begin
            r.pred.target = rnd[4] ? r.target : r.target + 32'd8;
        end else begin
            r.pred.target = r.pc + 32'd4;
        end
    endtask

    task automatic test_counters();
        resolve_t r;
        logic     fl;
        for (int i = 0; i < 40; i++) begin
            make_random_resolve(r);
            fl = $random(seed) & 1;
            send_resolve(r, fl);
        end
        check_perf(exp_perf, perf);
        check_bit("halt", exp_halt, halt);
    endtask

    task automatic test_halt();
        resolve_t r;
        r        = '0;
        r.pc     = random_pc();
        r.kind   = br_jal;
        r.taken  = 1'b1;
        r.target = r.pc;
        r.pred   = expect_pred(r.pc, 1'b0, br_none, 1'b0, '0);
        send_resolve(r, 1'b0);
        check_bit("halt", exp_halt, halt);
        // sticky through later traffic
        for (int i = 0; i < 3; i++) begin
            make_random_resolve(r);
            send_resolve(r, 1'b0);
            check_bit("halt", 1'b1, halt);
        end
        check_perf(exp_perf, perf);
    endtask

    initial begin
        fetch_valid   = 1'b0;
        fetch_pc      = '0;
        stall         = 1'b0;
        flush         = 1'b0;
        resolve_valid = 1'b0;
        resolve       = '0;
        err_count     = 0;
        seed          = 3166;
        exp_perf      = '0;
        hist_model    = '0;
        exp_halt      = 1'b0;
        jal_pc        = '0;
        jal_target    = '0;
        // weakly not taken, weakly bimodal
        for (int i = 0; i < `BHT_ENTRIES; i++) begin
            bim_model[i] = 2'b01;
            gsh_model[i] = 2'b01;
            cho_model[i] = 2'b01;
        end
        wait (rst_n === 1'b1);
        tick();
        test_reset();
        test_jal_training();
        test_cond_training();
        test_stall_hold();
        test_counters();
        test_halt();
        $display("errors: %0d", err_count);
        if (err_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // watchdog sized from the test count
    initial begin
        #(NUM_TESTS * TEST_CYCLES * CLK_NS);
        $display("timeout: run did not finish within %0d ns", NUM_TESTS * TEST_CYCLES * CLK_NS);
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+verilog
verilog/bp_pkg.sv
verilog/btb.sv
verilog/tournament_pred.sv
verilog/perf_counters.sv
verilog/branch_predict_unit.sv
verification/tb_clock.sv
verification/bp_tb.sv

// File: Makefile
# Verilator build and run of the branch predictor testbench

OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run bp_tb, search the log for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary -Wno-fatal -f sim.f --top-module bp_tb -Mdir $(OBJ_DIR) -o bp_sim
	./$(OBJ_DIR)/bp_sim | tee $(LOG)
	@if grep -qx "All tests passed" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
